// File: flist.f
poly_pkg.sv
coef_mem.sv
wb_arbiter.sv
pwo_alu.sv
pwo_ctrl.sv
poly_top.sv
tb_poly_top.sv

// File: run.sh
#!/bin/sh
# Build the coprocessor testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_poly_top -o sim_tb_poly_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_poly_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: tb_poly_top.sv
// Testbench that checks table rows of pointwise coprocessor operations against a modular model
module tb_poly_top;

    localparam int HOST_TIMEOUT = 500;
    localparam int DONE_TIMEOUT = 40000;
    localparam int NUM_ROWS     = 8;
    localparam int NUM_COEF     = 256;
    localparam logic [poly_pkg::MEM_ADDR_W-1:0] REF_BASE = 10'd768;

    // Pattern 0 is random, 1 uses q-1 operands and 2 puts every a below its b
    typedef struct packed {
        poly_pkg::pwo_mode_e             mode;
        logic [poly_pkg::MEM_ADDR_W-1:0] a_base;
        logic [poly_pkg::MEM_ADDR_W-1:0] b_base;
        logic [poly_pkg::MEM_ADDR_W-1:0] c_base;
        logic [1:0]                      pattern;
        logic                            host_rd;
        logic                            restart;
    } row_t;

    logic                            clk;
    logic                            rst_i;
    poly_pkg::wb_req_t               host_req;
    poly_pkg::wb_rsp_t               host_rsp;
    logic                            start;
    poly_pkg::pwo_mode_e             mode;
    logic [poly_pkg::MEM_ADDR_W-1:0] a_base;
    logic [poly_pkg::MEM_ADDR_W-1:0] b_base;
    logic [poly_pkg::MEM_ADDR_W-1:0] c_base;
    logic                            busy;
    logic                            done;

    row_t                        rows [NUM_ROWS];
    logic [poly_pkg::COEF_W-1:0] a_vals [NUM_COEF];
    logic [poly_pkg::COEF_W-1:0] b_vals [NUM_COEF];
    int                          errors;
    int                          timeouts;
    int                          done_cnt;
    int unsigned                 seed_val;
    logic [poly_pkg::COEF_W-1:0] rd_dat;

    poly_top poly_top_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .start_i    (start),
        .mode_i     (mode),
        .a_base_i   (a_base),
        .b_base_i   (b_base),
        .c_base_i   (c_base),
        .busy_o     (busy),
        .done_o     (done)
    );

    always #5 clk = ~clk;

    // Count done pulses mid-cycle
    // busy_o must already be low while done_o is high
    always @(negedge clk) begin
        if (done) begin
            done_cnt = done_cnt + 1;
            if (busy) begin
                $display("Error: busy_o expected 0 got %0h during done_o", busy);
                errors = errors + 1;
            end
        end
    end

    function automatic logic [poly_pkg::COEF_W-1:0] model_op(
        input poly_pkg::pwo_mode_e         m,
        input logic [poly_pkg::COEF_W-1:0] a,
        input logic [poly_pkg::COEF_W-1:0] b
    );
        logic [63:0] q;
        logic [63:0] r;
        q = 64'(poly_pkg::MLDSA_Q);
        case (m)
            poly_pkg::PWO_ADD: r = (64'(a) + 64'(b)) % q;
            poly_pkg::PWO_SUB: r = (64'(a) + q - 64'(b)) % q;
            default:           r = (64'(a) * 64'(b)) % q;
        endcase
        return r[poly_pkg::COEF_W-1:0];
    endfunction

    // Every address bit changes the reference word
    function automatic logic [poly_pkg::COEF_W-1:0] ref_word(
        input logic [poly_pkg::MEM_ADDR_W-1:0] adr
    );
        logic [31:0] v;
        v = (32'(adr) * 32'd40503) ^ 32'h005a5a5;
        return 24'(v % 32'(poly_pkg::MLDSA_Q));
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_cycle(
        input  logic                            we,
        input  logic [poly_pkg::MEM_ADDR_W-1:0] adr,
        input  logic [poly_pkg::COEF_W-1:0]     wdat,
        output logic [poly_pkg::COEF_W-1:0]     rdat
    );
        int t;
        t = 0;
        rdat = '0;
        if (timeouts == 0) begin
            host_req.cyc = 1'b1;
            host_req.stb = 1'b1;
            host_req.we  = we;
            host_req.adr = adr;
            host_req.dat = wdat;
            step();
            while (!host_rsp.ack && t < HOST_TIMEOUT) begin
                step();
                t = t + 1;
            end
            if (!host_rsp.ack) begin
                $display("Timeout: host access to address %03h was never acknowledged", adr);
                timeouts = timeouts + 1;
            end
            rdat = host_rsp.dat;
            host_req = '0;
            step();
        end
    endtask

    task automatic host_write(
        input logic [poly_pkg::MEM_ADDR_W-1:0] adr,
        input logic [poly_pkg::COEF_W-1:0]     dat
    );
        logic [poly_pkg::COEF_W-1:0] unused_dat;
        bus_cycle(1'b1, adr, dat, unused_dat);
    endtask

    task automatic host_read(
        input  logic [poly_pkg::MEM_ADDR_W-1:0] adr,
        output logic [poly_pkg::COEF_W-1:0]     dat
    );
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic wait_done(input int target);
        int t;
        t = 0;
        if (timeouts == 0) begin
            while (done_cnt < target && t < DONE_TIMEOUT) begin
                step();
                t = t + 1;
            end
            if (done_cnt < target) begin
                $display("Timeout: the engine never signalled done");
                timeouts = timeouts + 1;
            end
        end
    endtask

    task automatic pulse_start(input poly_pkg::pwo_mode_e m);
        mode  = m;
        start = 1'b1;
        step();
        start = 1'b0;
    endtask

    task automatic make_operands(input logic [1:0] pattern);
        for (int k = 0; k < NUM_COEF; k++) begin
            case (pattern)
                2'd1: begin
                    a_vals[k] = poly_pkg::MLDSA_Q - 24'd1;
                    b_vals[k] = 24'($urandom % 32'(poly_pkg::MLDSA_Q));
                    if (k % 4 == 0) begin
                        b_vals[k] = poly_pkg::MLDSA_Q - 24'd1;
                    end
                end
                2'd2: begin
                    a_vals[k] = 24'(k * 3);
                    b_vals[k] = poly_pkg::MLDSA_Q - 24'd1 - 24'(k);
                end
                default: begin
                    a_vals[k] = 24'($urandom % 32'(poly_pkg::MLDSA_Q));
                    b_vals[k] = 24'($urandom % 32'(poly_pkg::MLDSA_Q));
                end
            endcase
        end
    endtask

    task automatic run_row(input row_t r);
        logic [poly_pkg::COEF_W-1:0]     got;
        logic [poly_pkg::COEF_W-1:0]     exp;
        logic [poly_pkg::MEM_ADDR_W-1:0] adr;
        int                              target;
        poly_pkg::pwo_mode_e             other_mode;
        make_operands(r.pattern);
        for (int k = 0; k < NUM_COEF; k++) begin
            host_write(r.a_base + 10'(k), a_vals[k]);
            host_write(r.b_base + 10'(k), b_vals[k]);
        end
        target = done_cnt + 1;
        a_base = r.a_base;
        b_base = r.b_base;
        c_base = r.c_base;
        pulse_start(r.mode);
        if (r.restart) begin
            if (!busy) begin
                $display("Error: busy_o expected 1 got %0h after start", busy);
                errors = errors + 1;
            end
            // A second start with another mode must be ignored
            if (r.mode == poly_pkg::PWO_SUB) begin
                other_mode = poly_pkg::PWO_ADD;
            end else begin
                other_mode = poly_pkg::PWO_SUB;
            end
            pulse_start(other_mode);
        end
        if (r.host_rd) begin
            for (int k = 0; k < 16; k++) begin
                adr = REF_BASE + 10'(k * 13);
                if (timeouts == 0 && !busy) begin
                    $display("Error: busy_o expected 1 got %0h before host read at %03h",
                             busy, adr);
                    errors = errors + 1;
                end
                host_read(adr, got);
                if (timeouts == 0 && got !== ref_word(adr)) begin
                    $display("Error: host_rsp_o.dat at %03h expected %06h got %06h",
                             adr, ref_word(adr), got);
                    errors = errors + 1;
                end
            end
        end
        wait_done(target);
        if (timeouts == 0 && busy) begin
            $display("Error: busy_o expected 0 got %0h after done_o", busy);
            errors = errors + 1;
        end
        for (int k = 0; k < NUM_COEF; k++) begin
            adr = r.c_base + 10'(k);
            host_read(adr, got);
            exp = model_op(r.mode, a_vals[k], b_vals[k]);
            if (timeouts == 0 && got !== exp) begin
                $display("Error: host_rsp_o.dat at %03h expected %06h got %06h", adr, exp, got);
                errors = errors + 1;
            end
        end
        if (timeouts == 0 && done_cnt != target) begin
            $display("Error: done_o pulse count expected %0h got %0h", target, done_cnt);
            errors = errors + 1;
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_i    = 1'b1;
        host_req = '0;
        start    = 1'b0;
        mode     = poly_pkg::PWO_MUL;
        a_base   = '0;
        b_base   = '0;
        c_base   = '0;
        errors   = 0;
        timeouts = 0;
        done_cnt = 0;
        seed_val = $urandom(9);
        rows[0] = '{poly_pkg::PWO_ADD, 10'd0, 10'd256, 10'd512, 2'd0, 1'b0, 1'b0};
        rows[1] = '{poly_pkg::PWO_ADD, 10'd0, 10'd256, 10'd512, 2'd1, 1'b0, 1'b0};
        rows[2] = '{poly_pkg::PWO_SUB, 10'd0, 10'd256, 10'd512, 2'd0, 1'b0, 1'b0};
        rows[3] = '{poly_pkg::PWO_SUB, 10'd0, 10'd256, 10'd512, 2'd2, 1'b0, 1'b0};
        rows[4] = '{poly_pkg::PWO_MUL, 10'd0, 10'd256, 10'd512, 2'd1, 1'b0, 1'b0};
        rows[5] = '{poly_pkg::PWO_MUL, 10'd0, 10'd256, 10'd512, 2'd0, 1'b1, 1'b0};
        rows[6] = '{poly_pkg::PWO_SUB, 10'd256, 10'd0, 10'd512, 2'd0, 1'b1, 1'b0};
        rows[7] = '{poly_pkg::PWO_MUL, 10'd0, 10'd256, 10'd512, 2'd0, 1'b0, 1'b1};
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        if (busy || done || host_rsp.ack) begin
            $display("Error: busy_o, done_o, host_rsp_o.ack expected 0 got %0h %0h %0h",
                     busy, done, host_rsp.ack);
            errors = errors + 1;
        end
        step();
        // Reference region stays untouched by the engine and is reread during operations
        for (int k = 0; k < NUM_COEF; k++) begin
            host_write(REF_BASE + 10'(k), ref_word(REF_BASE + 10'(k)));
        end
        for (int k = 0; k < NUM_COEF; k++) begin
            host_read(REF_BASE + 10'(k), rd_dat);
            if (timeouts == 0 && rd_dat !== ref_word(REF_BASE + 10'(k))) begin
                $display("Error: host_rsp_o.dat at %03h expected %06h got %06h",
                         REF_BASE + 10'(k), ref_word(REF_BASE + 10'(k)), rd_dat);
                errors = errors + 1;
            end
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (timeouts == 0) begin
                run_row(rows[r]);
            end
        end
        $display("Summary: %0d errors, %0d timeouts, %0d done pulses", errors, timeouts, done_cnt);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: poly_top.sv
// Coprocessor top, host port and pointwise engine sharing one coefficient memory
module poly_top (
    input  logic                            clk,
    input  logic                            rst_i,
    input  poly_pkg::wb_req_t               host_req_i,
    output poly_pkg::wb_rsp_t               host_rsp_o,
    input  logic                            start_i,
    input  poly_pkg::pwo_mode_e             mode_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] a_base_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] b_base_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] c_base_i,
    output logic                            busy_o,
    output logic                            done_o
);

    poly_pkg::wb_req_t           eng_req;
    poly_pkg::wb_rsp_t           eng_rsp;
    poly_pkg::wb_req_t           mem_req;
    poly_pkg::wb_rsp_t           mem_rsp;
    logic                        alu_in_valid;
    poly_pkg::pwo_mode_e         alu_mode;
    logic [poly_pkg::COEF_W-1:0] alu_a;
    logic [poly_pkg::COEF_W-1:0] alu_b;
    logic                        alu_out_valid;
    logic [poly_pkg::COEF_W-1:0] alu_res;

    pwo_ctrl pwo_ctrl_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .mode_i      (mode_i),
        .a_base_i    (a_base_i),
        .b_base_i    (b_base_i),
        .c_base_i    (c_base_i),
        .bus_req_o   (eng_req),
        .bus_rsp_i   (eng_rsp),
        .alu_valid_o (alu_in_valid),
        .alu_mode_o  (alu_mode),
        .alu_a_o     (alu_a),
        .alu_b_o     (alu_b),
        .alu_valid_i (alu_out_valid),
        .alu_res_i   (alu_res),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    pwo_alu pwo_alu_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (alu_in_valid),
        .mode_i  (alu_mode),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .valid_o (alu_out_valid),
        .res_o   (alu_res)
    );

    // Host on port 0, engine on the priority port 1
    wb_arbiter wb_arbiter_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .m0_req_i (host_req_i),
        .m0_rsp_o (host_rsp_o),
        .m1_req_i (eng_req),
        .m1_rsp_o (eng_rsp),
        .s_req_o  (mem_req),
        .s_rsp_i  (mem_rsp)
    );

    coef_mem coef_mem_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus_req_i (mem_req),
        .bus_rsp_o (mem_rsp)
    );

endmodule

// File: pwo_ctrl.sv
// Pointwise engine sequencer, a Wishbone master that reads A and B, feeds the ALU and writes C
module pwo_ctrl (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  poly_pkg::pwo_mode_e             mode_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] a_base_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] b_base_i,
    input  logic [poly_pkg::MEM_ADDR_W-1:0] c_base_i,
    output poly_pkg::wb_req_t               bus_req_o,
    input  poly_pkg::wb_rsp_t               bus_rsp_i,
    output logic                            alu_valid_o,
    output poly_pkg::pwo_mode_e             alu_mode_o,
    output logic [poly_pkg::COEF_W-1:0]     alu_a_o,
    output logic [poly_pkg::COEF_W-1:0]     alu_b_o,
    input  logic                            alu_valid_i,
    input  logic [poly_pkg::COEF_W-1:0]     alu_res_i,
    output logic                            busy_o,
    output logic                            done_o
);

    poly_pkg::ctrl_state_e           state_q;
    poly_pkg::pwo_mode_e             mode_q;
    logic [poly_pkg::MEM_ADDR_W-1:0] a_base_q;
    logic [poly_pkg::MEM_ADDR_W-1:0] b_base_q;
    logic [poly_pkg::MEM_ADDR_W-1:0] c_base_q;
    poly_pkg::wb_req_t               req_q;
    logic                            gap_q;
    logic [poly_pkg::IDX_W:0]        rd_idx_q;
    logic [poly_pkg::IDX_W:0]        wr_cnt_q;
    logic [poly_pkg::IDX_W-1:0]      res_idx_q;
    logic [poly_pkg::COEF_W-1:0]     a_q;
    logic [poly_pkg::COEF_W-1:0]     b_q;
    logic                            alu_valid_q;
    logic [1:0]                      buf_cnt_q;
    logic [poly_pkg::COEF_W-1:0]     buf_dat_q [2];
    logic [poly_pkg::IDX_W-1:0]      buf_idx_q [2];
    logic                            push;
    logic                            pop;

    function automatic poly_pkg::wb_req_t bus_cycle(
        input logic                            we,
        input logic [poly_pkg::MEM_ADDR_W-1:0] base,
        input logic [poly_pkg::IDX_W-1:0]      idx,
        input logic [poly_pkg::COEF_W-1:0]     dat
    );
        poly_pkg::wb_req_t r;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = base + {{(poly_pkg::MEM_ADDR_W - poly_pkg::IDX_W){1'b0}}, idx};
        r.dat = dat;
        return r;
    endfunction

    // Main FSM, cyc stays low two cycles between accesses so the host can win the bus
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= poly_pkg::IDLE;
            req_q       <= '0;
            gap_q       <= 1'b0;
            rd_idx_q    <= '0;
            wr_cnt_q    <= '0;
            res_idx_q   <= '0;
            alu_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= 1'b0;
            if (alu_valid_i) begin
                res_idx_q <= res_idx_q + 1'b1;
            end
            case (state_q)
                poly_pkg::IDLE: begin
                    if (start_i) begin
                        rd_idx_q  <= '0;
                        wr_cnt_q  <= '0;
                        res_idx_q <= '0;
                        gap_q     <= 1'b0;
                        state_q   <= poly_pkg::CALC;
                    end
                end
                poly_pkg::RD_A: begin
                    if (bus_rsp_i.ack) begin
                        req_q   <= '0;
                        gap_q   <= 1'b1;
                        state_q <= poly_pkg::RD_B;
                    end
                end
                poly_pkg::RD_B: begin
                    if (req_q.cyc) begin
                        if (bus_rsp_i.ack) begin
                            // Operand pair goes to the ALU next cycle
                            req_q       <= '0;
                            gap_q       <= 1'b1;
                            alu_valid_q <= 1'b1;
                            rd_idx_q    <= rd_idx_q + 1'b1;
                            state_q     <= poly_pkg::CALC;
                        end
                    end else if (gap_q) begin
                        gap_q <= 1'b0;
                    end else begin
                        req_q <= bus_cycle(1'b0, b_base_q, rd_idx_q[poly_pkg::IDX_W-1:0], '0);
                    end
                end
                poly_pkg::CALC: begin
                    // Buffered results drain before new reads
                    if (gap_q) begin
                        gap_q <= 1'b0;
                    end else if (buf_cnt_q != 2'd0) begin
                        req_q   <= bus_cycle(1'b1, c_base_q, buf_idx_q[0], buf_dat_q[0]);
                        state_q <= poly_pkg::WR_C;
                    end else if (rd_idx_q != poly_pkg::POLY_N) begin
                        req_q   <= bus_cycle(1'b0, a_base_q, rd_idx_q[poly_pkg::IDX_W-1:0], '0);
                        state_q <= poly_pkg::RD_A;
                    end
                end
                poly_pkg::WR_C: begin
                    if (bus_rsp_i.ack) begin
                        req_q    <= '0;
                        wr_cnt_q <= wr_cnt_q + 1'b1;
                        if (wr_cnt_q == poly_pkg::POLY_N - 1'b1) begin
                            state_q <= poly_pkg::FINISH;
                        end else begin
                            gap_q   <= 1'b1;
                            state_q <= poly_pkg::CALC;
                        end
                    end
                end
                poly_pkg::FINISH: state_q <= poly_pkg::IDLE;
                default:          state_q <= poly_pkg::IDLE;
            endcase
        end
    end

    // Operation setup and operands
    always_ff @(posedge clk) begin
        if (state_q == poly_pkg::IDLE && start_i) begin
            mode_q   <= mode_i;
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
        if (state_q == poly_pkg::RD_A && bus_rsp_i.ack) begin
            a_q <= bus_rsp_i.dat;
        end
        if (state_q == poly_pkg::RD_B && bus_rsp_i.ack) begin
            b_q <= bus_rsp_i.dat;
        end
    end

    // Two-entry result buffer, head at entry 0
    assign push = alu_valid_i;
    assign pop  = (state_q == poly_pkg::WR_C) && bus_rsp_i.ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            buf_cnt_q <= '0;
        end else if (push && !pop) begin
            buf_cnt_q <= buf_cnt_q + 1'b1;
        end else if (pop && !push) begin
            buf_cnt_q <= buf_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            buf_dat_q[0] <= buf_dat_q[1];
            buf_idx_q[0] <= buf_idx_q[1];
        end
        if (push) begin
            // Lands in the first slot that is free after this cycle's pop
            if (buf_cnt_q == 2'd0 || (pop && buf_cnt_q == 2'd1)) begin
                buf_dat_q[0] <= alu_res_i;
                buf_idx_q[0] <= res_idx_q;
            end else begin
                buf_dat_q[1] <= alu_res_i;
                buf_idx_q[1] <= res_idx_q;
            end
        end
    end

    assign bus_req_o   = req_q;
    assign alu_valid_o = alu_valid_q;
    assign alu_mode_o  = mode_q;
    assign alu_a_o     = a_q;
    assign alu_b_o     = b_q;
    assign busy_o      = (state_q != poly_pkg::IDLE) && (state_q != poly_pkg::FINISH);
    assign done_o      = (state_q == poly_pkg::FINISH);

endmodule

// File: pwo_alu.sv
// Two-stage modular add, subtract and multiply unit for coefficients mod q
module pwo_alu (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        valid_i,
    input  poly_pkg::pwo_mode_e         mode_i,
    input  logic [poly_pkg::COEF_W-1:0] a_i,
    input  logic [poly_pkg::COEF_W-1:0] b_i,
    output logic                        valid_o,
    output logic [poly_pkg::COEF_W-1:0] res_o
);

    logic [poly_pkg::RAW_W-1:0]  q_wide;
    logic [poly_pkg::RAW_W-1:0]  a_wide;
    logic [poly_pkg::RAW_W-1:0]  b_wide;
    logic [poly_pkg::RAW_W-1:0]  raw_d;
    logic [poly_pkg::RAW_W-1:0]  raw_q;
    logic [poly_pkg::RAW_W-1:0]  red_d;
    poly_pkg::pwo_mode_e         mode_q;
    logic                        valid_q1;
    logic                        valid_q2;
    logic [poly_pkg::COEF_W-1:0] res_q;

    assign q_wide = {{poly_pkg::COEF_W{1'b0}}, poly_pkg::MLDSA_Q};
    assign a_wide = {{poly_pkg::COEF_W{1'b0}}, a_i};
    assign b_wide = {{poly_pkg::COEF_W{1'b0}}, b_i};

    // Stage 1 raw value, q is added first so the difference stays positive
    always_comb begin
        case (mode_i)
            poly_pkg::PWO_ADD: raw_d = a_wide + b_wide;
            poly_pkg::PWO_SUB: raw_d = a_wide + q_wide - b_wide;
            default:           raw_d = a_wide * b_wide;
        endcase
    end

    // Stage 2, sums are below 2q so one conditional subtract is enough
    always_comb begin
        if (mode_q == poly_pkg::PWO_MUL) begin
            red_d = raw_q % q_wide;
        end else if (raw_q >= q_wide) begin
            red_d = raw_q - q_wide;
        end else begin
            red_d = raw_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= valid_i;
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge clk) begin
        raw_q  <= raw_d;
        mode_q <= mode_i;
        res_q  <= red_d[poly_pkg::COEF_W-1:0];
    end

    assign valid_o = valid_q2;
    assign res_o   = res_q;

endmodule

// File: wb_arbiter.sv
// Two-master Wishbone classic arbiter, engine first, grant held for a whole bus cycle
module wb_arbiter (
    input  logic              clk,
    input  logic              rst_i,
    input  poly_pkg::wb_req_t m0_req_i,
    output poly_pkg::wb_rsp_t m0_rsp_o,
    input  poly_pkg::wb_req_t m1_req_i,
    output poly_pkg::wb_rsp_t m1_rsp_o,
    output poly_pkg::wb_req_t s_req_o,
    input  poly_pkg::wb_rsp_t s_rsp_i
);

    // Owner 1 is the engine, owner 0 the host
    logic locked_q;
    logic owner_q;
    logic sel;
    logic owner_cyc;

    // Free bus goes to a requester in the same cycle, engine wins a tie
    always_comb begin
        if (locked_q) begin
            sel = owner_q;
        end else begin
            sel = m1_req_i.cyc;
        end
    end

    assign owner_cyc = owner_q ? m1_req_i.cyc : m0_req_i.cyc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            locked_q <= 1'b0;
            owner_q  <= 1'b0;
        end else if (locked_q) begin
            // Release once the owner has let go of cyc
            if (!owner_cyc) begin
                locked_q <= 1'b0;
            end
        end else if (m0_req_i.cyc || m1_req_i.cyc) begin
            locked_q <= 1'b1;
            owner_q  <= m1_req_i.cyc;
        end
    end

    assign s_req_o = sel ? m1_req_i : m0_req_i;

    // Waiting master never sees an ack
    always_comb begin
        m0_rsp_o.dat = s_rsp_i.dat;
        m1_rsp_o.dat = s_rsp_i.dat;
        m0_rsp_o.ack = 1'b0;
        m1_rsp_o.ack = 1'b0;
        if (sel) begin
            m1_rsp_o.ack = s_rsp_i.ack;
        end else begin
            m0_rsp_o.ack = s_rsp_i.ack;
        end
    end

endmodule

// File: coef_mem.sv
// Single-port coefficient RAM behind a Wishbone classic slave with registered ack
module coef_mem (
    input  logic              clk,
    input  logic              rst_i,
    input  poly_pkg::wb_req_t bus_req_i,
    output poly_pkg::wb_rsp_t bus_rsp_o
);

    logic [poly_pkg::COEF_W-1:0] mem_q [0:(1 << poly_pkg::MEM_ADDR_W)-1];
    logic [poly_pkg::COEF_W-1:0] rdat_q;
    logic                        ack_q;
    logic                        access;

    // A strobe is served once, the ack cycle blocks a second hit
    assign access = bus_req_i.cyc && bus_req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Read data comes back with the ack
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus_req_i.we) begin
                mem_q[bus_req_i.adr] <= bus_req_i.dat;
            end
            rdat_q <= mem_q[bus_req_i.adr];
        end
    end

    assign bus_rsp_o.ack = ack_q;
    assign bus_rsp_o.dat = rdat_q;

endmodule

// File: poly_pkg.sv
// Shared constants, enums and Wishbone bus structs for the pointwise polynomial coprocessor
package poly_pkg;

    // ML-DSA prime modulus
    localparam int COEF_W = 24;
    localparam logic [COEF_W-1:0] MLDSA_Q = 24'd8380417;

    // Double width holds a full product before reduction
    localparam int RAW_W = 2 * COEF_W;

    // One polynomial is 256 coefficients, the counter needs one extra bit
    localparam int IDX_W = 8;
    localparam logic [IDX_W:0] POLY_N = 256;

    // Room for four polynomials
    localparam int MEM_ADDR_W = 10;

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_e;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        RD_A   = 3'd1,
        RD_B   = 3'd2,
        CALC   = 3'd3,
        WR_C   = 3'd4,
        FINISH = 3'd5
    } ctrl_state_e;

    // Master to slave, Wishbone classic
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [MEM_ADDR_W-1:0] adr;
        logic [COEF_W-1:0]     dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic              ack;
        logic [COEF_W-1:0] dat;
    } wb_rsp_t;

endpackage
